// ==== hdl/cache_settings.svh ====
// cache settings: geometry and sizes of the L1 data cache store and its victim buffer
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// set-associative array geometry
`define CACHE_NUM_SETS 8
`define CACHE_SET_BITS 3

// ways must be a power of two, at least 2, for the plru tree
`define CACHE_NUM_WAYS 4
`define CACHE_WAY_BITS 2

// block address is tag over set
`define CACHE_TAG_BITS 10
`define CACHE_ADDR_BITS 13

// one line per block, no byte offsets
`define CACHE_DATA_BITS 64

// victim buffer depth
`define VB_ENTRIES 4

`endif

// ==== hdl/cache_pkg.sv ====
// cache package: block address type shared by the array, victim buffer and top
`default_nettype none

`include "cache_settings.svh"

package cache_pkg;

	// tag and set view of a block address
	typedef struct packed {
		logic [`CACHE_TAG_BITS-1:0] tag;
		logic [`CACHE_SET_BITS-1:0] set_idx;
	} block_fields_t;

	// array splits the address into fields, victim buffer compares the raw word
	typedef union packed {
		logic [`CACHE_ADDR_BITS-1:0] word;
		block_fields_t fields;
	} block_addr_u;

endpackage

`default_nettype wire

// ==== hdl/tag_match.sv ====
// tag match: compares a tag against every valid way of a set and encodes the hit way
`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

module tag_match (
	input  wire logic [`CACHE_TAG_BITS-1:0] tag,
	input  wire logic [`CACHE_NUM_WAYS-1:0][`CACHE_TAG_BITS-1:0] way_tags,
	input  wire logic [`CACHE_NUM_WAYS-1:0] way_valid,
	output logic hit,
	output logic [`CACHE_WAY_BITS-1:0] hit_way
);

	logic [`CACHE_NUM_WAYS-1:0] match;

	for (genvar i = 0; i < `CACHE_NUM_WAYS; i++) begin : g_cmp
		assign match[i] = way_valid[i] && (way_tags[i] == tag);
	end

	assign hit = |match;

	// at most one way matches, so an or of indices is a one-hot encoder
	always_comb begin
		hit_way = '0;
		for (int i = 0; i < `CACHE_NUM_WAYS; i++) begin
			if (match[i]) begin
				hit_way = hit_way | `CACHE_WAY_BITS'(i);
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/plru_tree.sv ====
// plru tree: per-set tree pseudo-LRU state with ordered write and read touches
`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

module plru_tree (
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic wr_touch,
	input  wire logic [`CACHE_SET_BITS-1:0] wr_set,
	input  wire logic [`CACHE_WAY_BITS-1:0] wr_way,
	input  wire logic rd_touch,
	input  wire logic [`CACHE_SET_BITS-1:0] rd_set,
	input  wire logic [`CACHE_WAY_BITS-1:0] rd_way,
	input  wire logic [`CACHE_SET_BITS-1:0] victim_set,
	output logic [`CACHE_WAY_BITS-1:0] victim_way
);

	localparam int NODES = `CACHE_NUM_WAYS - 1;

	// heap order: node n has children 2n+1 (lower ways) and 2n+2 (upper ways)
	logic [`CACHE_NUM_SETS-1:0][NODES-1:0] tree_q;
	logic [`CACHE_NUM_SETS-1:0][NODES-1:0] tree_next;

	// point every node on the way's path away from it
	function automatic logic [NODES-1:0] touch_path(
		input logic [NODES-1:0] bits,
		input logic [`CACHE_WAY_BITS-1:0] way
	);
		logic [NODES-1:0] result;
		int node;
		result = bits;
		node = 0;
		for (int lvl = 0; lvl < `CACHE_WAY_BITS; lvl++) begin
			if (way[`CACHE_WAY_BITS-1-lvl]) begin
				result[node] = 1'b0;
				node = 2 * node + 2;
			end else begin
				result[node] = 1'b1;
				node = 2 * node + 1;
			end
		end
		return result;
	endfunction

	// write touch first, read touch on top of it
	always_comb begin
		tree_next = tree_q;
		if (wr_touch) begin
			tree_next[wr_set] = touch_path(tree_next[wr_set], wr_way);
		end
		if (rd_touch) begin
			tree_next[rd_set] = touch_path(tree_next[rd_set], rd_way);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			tree_q <= '0;
		end else begin
			tree_q <= tree_next;
		end
	end

	// follow the bits from the root, msb of the way first
	always_comb begin
		int node;
		logic b;
		node = 0;
		victim_way = '0;
		for (int lvl = 0; lvl < `CACHE_WAY_BITS; lvl++) begin
			b = tree_q[victim_set][node];
			victim_way[`CACHE_WAY_BITS-1-lvl] = b;
			if (b) begin
				node = 2 * node + 2;
			end else begin
				node = 2 * node + 1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/cache_array.sv ====
// cache array: set-associative tag, valid and data store with lookup, fill and eviction
`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

module cache_array (
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic rd_en,
	input  wire cache_pkg::block_addr_u rd_addr,
	input  wire logic wr_en,
	input  wire cache_pkg::block_addr_u wr_addr,
	input  wire logic [`CACHE_DATA_BITS-1:0] wr_data,
	output logic rd_hit,
	output logic [`CACHE_DATA_BITS-1:0] rd_data,
	output logic evict_valid,
	output cache_pkg::block_addr_u evict_addr,
	output logic [`CACHE_DATA_BITS-1:0] evict_data
);

	logic [`CACHE_NUM_SETS-1:0][`CACHE_NUM_WAYS-1:0] valid_q;
	logic [`CACHE_TAG_BITS-1:0] tag_mem [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
	logic [`CACHE_DATA_BITS-1:0] data_mem [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];

	logic [`CACHE_SET_BITS-1:0] rd_set;
	logic [`CACHE_SET_BITS-1:0] wr_set;
	logic [`CACHE_NUM_WAYS-1:0][`CACHE_TAG_BITS-1:0] rd_tags;
	logic [`CACHE_NUM_WAYS-1:0][`CACHE_TAG_BITS-1:0] wr_tags;

	logic rd_match;
	logic [`CACHE_WAY_BITS-1:0] rd_way;
	logic wr_match;
	logic [`CACHE_WAY_BITS-1:0] wr_way;

	logic has_invalid;
	logic [`CACHE_WAY_BITS-1:0] invalid_way;
	logic [`CACHE_WAY_BITS-1:0] plru_way;
	logic [`CACHE_WAY_BITS-1:0] fill_way;

	assign rd_set = rd_addr.fields.set_idx;
	assign wr_set = wr_addr.fields.set_idx;

	for (genvar i = 0; i < `CACHE_NUM_WAYS; i++) begin : g_tags
		assign rd_tags[i] = tag_mem[rd_set][i];
		assign wr_tags[i] = tag_mem[wr_set][i];
	end

	tag_match u_rd_match (
		.tag      (rd_addr.fields.tag),
		.way_tags (rd_tags),
		.way_valid(valid_q[rd_set]),
		.hit      (rd_match),
		.hit_way  (rd_way)
	);

	tag_match u_wr_match (
		.tag      (wr_addr.fields.tag),
		.way_tags (wr_tags),
		.way_valid(valid_q[wr_set]),
		.hit      (wr_match),
		.hit_way  (wr_way)
	);

	plru_tree u_plru_tree (
		.clock     (clock),
		.reset     (reset),
		.wr_touch  (wr_en),
		.wr_set    (wr_set),
		.wr_way    (fill_way),
		.rd_touch  (rd_hit),
		.rd_set    (rd_set),
		.rd_way    (rd_way),
		.victim_set(wr_set),
		.victim_way(plru_way)
	);

	assign rd_hit = rd_en && rd_match;
	assign rd_data = data_mem[rd_set][rd_way];

	// lowest-numbered invalid way of the write set
	always_comb begin
		has_invalid = 1'b0;
		invalid_way = '0;
		for (int i = `CACHE_NUM_WAYS - 1; i >= 0; i--) begin
			if (!valid_q[wr_set][i]) begin
				has_invalid = 1'b1;
				invalid_way = `CACHE_WAY_BITS'(i);
			end
		end
	end

	always_comb begin
		if (wr_match) begin
			fill_way = wr_way;
		end else if (has_invalid) begin
			fill_way = invalid_way;
		end else begin
			fill_way = plru_way;
		end
	end

	// a full set with no hit means the tree victim holds a valid, different line
	assign evict_valid = wr_en && !wr_match && !has_invalid;
	assign evict_data = data_mem[wr_set][fill_way];

	always_comb begin
		evict_addr.fields.tag = tag_mem[wr_set][fill_way];
		evict_addr.fields.set_idx = wr_set;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= '0;
		end else if (wr_en) begin
			valid_q[wr_set][fill_way] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (wr_en) begin
			tag_mem[wr_set][fill_way] <= wr_addr.fields.tag;
			data_mem[wr_set][fill_way] <= wr_data;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/victim_buffer.sv ====
// victim buffer: fully associative FIFO of evicted lines with lookup and write-back
`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

module victim_buffer (
	input  wire logic clock,
	input  wire logic reset,
	input  wire cache_pkg::block_addr_u rd_addr,
	input  wire logic evict_valid,
	input  wire cache_pkg::block_addr_u evict_addr,
	input  wire logic [`CACHE_DATA_BITS-1:0] evict_data,
	input  wire logic inval_en,
	input  wire cache_pkg::block_addr_u inval_addr,
	output logic vb_hit,
	output logic [`CACHE_DATA_BITS-1:0] vb_data,
	output logic wb_valid,
	output cache_pkg::block_addr_u wb_addr,
	output logic [`CACHE_DATA_BITS-1:0] wb_data
);

	// entry 0 is the oldest, valid entries are kept packed at the low end
	logic [`VB_ENTRIES-1:0] valid_q;
	logic [`CACHE_ADDR_BITS-1:0] addr_q [`VB_ENTRIES];
	logic [`CACHE_DATA_BITS-1:0] data_q [`VB_ENTRIES];

	logic [`VB_ENTRIES-1:0] valid_next;
	logic [`CACHE_ADDR_BITS-1:0] addr_next [`VB_ENTRIES];
	logic [`CACHE_DATA_BITS-1:0] data_next [`VB_ENTRIES];

	// addresses are unique in the buffer, so an or-mux is enough
	always_comb begin
		vb_hit = 1'b0;
		vb_data = '0;
		for (int i = 0; i < `VB_ENTRIES; i++) begin
			if (valid_q[i] && (addr_q[i] == rd_addr.word)) begin
				vb_hit = 1'b1;
				vb_data = vb_data | data_q[i];
			end
		end
	end

	always_comb begin
		int count;
		valid_next = '0;
		addr_next = addr_q;
		data_next = data_q;
		wb_valid = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		count = 0;

		// drop the invalidated entry and close the gap, order preserved
		for (int i = 0; i < `VB_ENTRIES; i++) begin
			if (valid_q[i] && !(inval_en && (addr_q[i] == inval_addr.word))) begin
				addr_next[count] = addr_q[i];
				data_next[count] = data_q[i];
				valid_next[count] = 1'b1;
				count++;
			end
		end

		if (evict_valid) begin
			if (count == `VB_ENTRIES) begin
				// full: oldest leaves as a write-back, the rest move down
				wb_valid = 1'b1;
				wb_addr.word = addr_next[0];
				wb_data = data_next[0];
				for (int i = 0; i < `VB_ENTRIES - 1; i++) begin
					addr_next[i] = addr_next[i+1];
					data_next[i] = data_next[i+1];
				end
				addr_next[`VB_ENTRIES-1] = evict_addr.word;
				data_next[`VB_ENTRIES-1] = evict_data;
			end else begin
				addr_next[count] = evict_addr.word;
				data_next[count] = evict_data;
				valid_next[count] = 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= '0;
		end else begin
			valid_q <= valid_next;
		end
	end

	always_ff @(posedge clock) begin
		addr_q <= addr_next;
		data_q <= data_next;
	end

endmodule

`default_nettype wire

// ==== hdl/l1_cache_top.sv ====
// l1 cache top: array plus victim buffer, read result merge and write-back port
`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

module l1_cache_top (
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic rd_en,
	input  wire cache_pkg::block_addr_u rd_addr,
	input  wire logic wr_en,
	input  wire cache_pkg::block_addr_u wr_addr,
	input  wire logic [`CACHE_DATA_BITS-1:0] wr_data,
	output logic rd_hit,
	output logic rd_miss,
	output logic [`CACHE_DATA_BITS-1:0] rd_data,
	output logic wb_valid,
	output cache_pkg::block_addr_u wb_addr,
	output logic [`CACHE_DATA_BITS-1:0] wb_data
);

	logic arr_hit;
	logic [`CACHE_DATA_BITS-1:0] arr_data;
	logic vb_hit;
	logic [`CACHE_DATA_BITS-1:0] vb_data;
	logic evict_valid;
	cache_pkg::block_addr_u evict_addr;
	logic [`CACHE_DATA_BITS-1:0] evict_data;

	cache_array u_cache_array (
		.clock      (clock),
		.reset      (reset),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.rd_hit     (arr_hit),
		.rd_data    (arr_data),
		.evict_valid(evict_valid),
		.evict_addr (evict_addr),
		.evict_data (evict_data)
	);

	// a write clears any stale copy of its address in the buffer
	victim_buffer u_victim_buffer (
		.clock      (clock),
		.reset      (reset),
		.rd_addr    (rd_addr),
		.evict_valid(evict_valid),
		.evict_addr (evict_addr),
		.evict_data (evict_data),
		.inval_en   (wr_en),
		.inval_addr (wr_addr),
		.vb_hit     (vb_hit),
		.vb_data    (vb_data),
		.wb_valid   (wb_valid),
		.wb_addr    (wb_addr),
		.wb_data    (wb_data)
	);

	// array hit wins over the buffer, arr_hit already carries rd_en
	assign rd_hit = arr_hit || (rd_en && vb_hit);
	assign rd_miss = rd_en && !arr_hit && !vb_hit;

	always_comb begin
		if (arr_hit) begin
			rd_data = arr_data;
		end else if (rd_en && vb_hit) begin
			rd_data = vb_data;
		end else begin
			rd_data = '0;
		end
	end

endmodule

`default_nettype wire

// ==== sim/cache_tb_vectors.svh ====
// cache testbench vectors: one row per cycle of stimulus and expected responses
// columns: rd_en, rd_addr, wr_en, wr_addr, wr_data, then
// expected rd_hit, rd_miss, rd_data, wb_valid, wb_addr, wb_data

// cold misses after reset
add_row(1, block_addr(10'h001, 3'd0), 0, 13'h0, 64'h0,
	0, 1, 64'h0, 0, 13'h0, 64'h0);
add_row(1, block_addr(10'h3ff, 3'd7), 0, 13'h0, 64'h0,
	0, 1, 64'h0, 0, 13'h0, 64'h0);

// write then read, same-cycle read sees the old contents
add_row(1, block_addr(10'h001, 3'd0), 1, block_addr(10'h001, 3'd0), 64'h0000_0000_aaaa_0001,
	0, 1, 64'h0, 0, 13'h0, 64'h0);
add_row(1, block_addr(10'h001, 3'd0), 0, 13'h0, 64'h0,
	1, 0, 64'h0000_0000_aaaa_0001, 0, 13'h0, 64'h0);
add_row(1, block_addr(10'h001, 3'd0), 1, block_addr(10'h001, 3'd0), 64'h0000_0000_aaaa_0002,
	1, 0, 64'h0000_0000_aaaa_0001, 0, 13'h0, 64'h0);
add_row(1, block_addr(10'h001, 3'd0), 0, 13'h0, 64'h0,
	1, 0, 64'h0000_0000_aaaa_0002, 0, 13'h0, 64'h0);

// fill set 2, ways 0 to 3
add_row(0, 13'h0, 1, block_addr(10'h010, 3'd2), 64'h0b0b_0000_0000_0010,
	0, 0, 64'h0, 0, 13'h0, 64'h0);
add_row(0, 13'h0, 1, block_addr(10'h011, 3'd2), 64'h0b0b_0000_0000_0011,
	0, 0, 64'h0, 0, 13'h0, 64'h0);
add_row(0, 13'h0, 1, block_addr(10'h012, 3'd2), 64'h0b0b_0000_0000_0012,
	0, 0, 64'h0, 0, 13'h0, 64'h0);
add_row(0, 13'h0, 1, block_addr(10'h013, 3'd2), 64'h0b0b_0000_0000_0013,
	0, 0, 64'h0, 0, 13'h0, 64'h0);

// steer the tree with reads of ways 0 and 2, victim becomes way 1
add_row(1, block_addr(10'h010, 3'd2), 0, 13'h0, 64'h0,
	1, 0, 64'h0b0b_0000_0000_0010, 0, 13'h0, 64'h0);
add_row(1, block_addr(10'h012, 3'd2), 0, 13'h0, 64'h0,
	1, 0, 64'h0b0b_0000_0000_0012, 0, 13'h0, 64'h0);
add_row(0, 13'h0, 1, block_addr(10'h014, 3'd2), 64'h0b0b_0000_0000_0014,
	0, 0, 64'h0, 0, 13'h0, 64'h0);
add_row(1, block_addr(10'h011, 3'd2), 0, 13'h0, 64'h0,
	1, 0, 64'h0b0b_0000_0000_0011, 0, 13'h0, 64'h0);
add_row(1, block_addr(10'h014, 3'd2), 0, 13'h0, 64'h0,
	1, 0, 64'h0b0b_0000_0000_0014, 0, 13'h0, 64'h0);

// evict ways 3, 0, 2 and 1, the fifth eviction writes back the first
add_row(0, 13'h0, 1, block_addr(10'h015, 3'd2), 64'h0b0b_0000_0000_0015,
	0, 0, 64'h0, 0, 13'h0, 64'h0);
add_row(0, 13'h0, 1, block_addr(10'h016, 3'd2), 64'h0b0b_0000_0000_0016,
	0, 0, 64'h0, 0, 13'h0, 64'h0);
add_row(0, 13'h0, 1, block_addr(10'h017, 3'd2), 64'h0b0b_0000_0000_0017,
	0, 0, 64'h0, 0, 13'h0, 64'h0);
add_row(0, 13'h0, 1, block_addr(10'h018, 3'd2), 64'h0b0b_0000_0000_0018,
	0, 0, 64'h0, 1, block_addr(10'h011, 3'd2), 64'h0b0b_0000_0000_0011);
add_row(1, block_addr(10'h011, 3'd2), 0, 13'h0, 64'h0,
	0, 1, 64'h0, 0, 13'h0, 64'h0);

// rewrite a buffered address, stale copy goes and no write-back follows
add_row(1, block_addr(10'h013, 3'd2), 1, block_addr(10'h013, 3'd2), 64'hc3c3_c3c3_0000_0013,
	1, 0, 64'h0b0b_0000_0000_0013, 0, 13'h0, 64'h0);
add_row(1, block_addr(10'h013, 3'd2), 0, 13'h0, 64'h0,
	1, 0, 64'hc3c3_c3c3_0000_0013, 0, 13'h0, 64'h0);
add_row(1, block_addr(10'h015, 3'd2), 0, 13'h0, 64'h0,
	1, 0, 64'h0b0b_0000_0000_0015, 0, 13'h0, 64'h0);
add_row(1, block_addr(10'h010, 3'd2), 0, 13'h0, 64'h0,
	1, 0, 64'h0b0b_0000_0000_0010, 0, 13'h0, 64'h0);

// write hit in the full set with the buffer full, any eviction would show as a write-back
add_row(1, block_addr(10'h016, 3'd2), 1, block_addr(10'h016, 3'd2), 64'hd4d4_d4d4_0000_0016,
	1, 0, 64'h0b0b_0000_0000_0016, 0, 13'h0, 64'h0);
add_row(1, block_addr(10'h016, 3'd2), 0, 13'h0, 64'h0,
	1, 0, 64'hd4d4_d4d4_0000_0016, 0, 13'h0, 64'h0);

add_row(0, 13'h0, 0, 13'h0, 64'h0,
	0, 0, 64'h0, 0, 13'h0, 64'h0);

// ==== sim/cache_tb.sv ====
// cache testbench: table-driven checks of reads, fills, replacement and write-back
`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

module cache_tb;

	localparam int CLOCK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;

	typedef struct packed {
		logic rd_en;
		logic [`CACHE_ADDR_BITS-1:0] rd_addr;
		logic wr_en;
		logic [`CACHE_ADDR_BITS-1:0] wr_addr;
		logic [`CACHE_DATA_BITS-1:0] wr_data;
		logic exp_hit;
		logic exp_miss;
		logic [`CACHE_DATA_BITS-1:0] exp_data;
		logic exp_wb;
		logic [`CACHE_ADDR_BITS-1:0] exp_wb_addr;
		logic [`CACHE_DATA_BITS-1:0] exp_wb_data;
	} vector_t;

	logic clock;
	logic reset;
	logic rd_en;
	cache_pkg::block_addr_u rd_addr;
	logic wr_en;
	cache_pkg::block_addr_u wr_addr;
	logic [`CACHE_DATA_BITS-1:0] wr_data;
	logic rd_hit;
	logic rd_miss;
	logic [`CACHE_DATA_BITS-1:0] rd_data;
	logic wb_valid;
	cache_pkg::block_addr_u wb_addr;
	logic [`CACHE_DATA_BITS-1:0] wb_data;

	vector_t table_q[$];
	int errors = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	l1_cache_top u_l1_cache_top (
		.clock   (clock),
		.reset   (reset),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_hit  (rd_hit),
		.rd_miss (rd_miss),
		.rd_data (rd_data),
		.wb_valid(wb_valid),
		.wb_addr (wb_addr),
		.wb_data (wb_data)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	// tag in the upper bits, set index in the lower bits
	function automatic logic [`CACHE_ADDR_BITS-1:0] block_addr(
		input logic [`CACHE_TAG_BITS-1:0] tag,
		input logic [`CACHE_SET_BITS-1:0] set_idx
	);
		return {tag, set_idx};
	endfunction

	task automatic add_row(
		input logic r_en, input logic [`CACHE_ADDR_BITS-1:0] r_addr,
		input logic w_en, input logic [`CACHE_ADDR_BITS-1:0] w_addr,
		input logic [`CACHE_DATA_BITS-1:0] w_data,
		input logic hit, input logic miss, input logic [`CACHE_DATA_BITS-1:0] data,
		input logic wb, input logic [`CACHE_ADDR_BITS-1:0] wb_a,
		input logic [`CACHE_DATA_BITS-1:0] wb_d
	);
		vector_t v;
		v = {r_en, r_addr, w_en, w_addr, w_data, hit, miss, data, wb, wb_a, wb_d};
		table_q.push_back(v);
	endtask

	task automatic load_table();
		`include "cache_tb_vectors.svh"
	endtask

	task automatic drive_row(input vector_t v);
		rd_en = v.rd_en;
		rd_addr.word = v.rd_addr;
		wr_en = v.wr_en;
		wr_addr.word = v.wr_addr;
		wr_data = v.wr_data;
	endtask

	// data and write-back fields only matter when their strobe is expected
	task automatic check_row(input int idx, input vector_t v);
		assert (rd_hit === v.exp_hit) else begin
			$display("[FAIL] %0t ns: row %0d rd_hit is %b, expected %b",
				$time, idx, rd_hit, v.exp_hit);
			errors++;
		end
		assert (rd_miss === v.exp_miss) else begin
			$display("[FAIL] %0t ns: row %0d rd_miss is %b, expected %b",
				$time, idx, rd_miss, v.exp_miss);
			errors++;
		end
		assert (!v.exp_hit || rd_data === v.exp_data) else begin
			$display("[FAIL] %0t ns: row %0d rd_data is %h, expected %h",
				$time, idx, rd_data, v.exp_data);
			errors++;
		end
		assert (wb_valid === v.exp_wb) else begin
			$display("[FAIL] %0t ns: row %0d wb_valid is %b, expected %b",
				$time, idx, wb_valid, v.exp_wb);
			errors++;
		end
		assert (!v.exp_wb || wb_addr.word === v.exp_wb_addr) else begin
			$display("[FAIL] %0t ns: row %0d wb_addr is %h, expected %h",
				$time, idx, wb_addr.word, v.exp_wb_addr);
			errors++;
		end
		assert (!v.exp_wb || wb_data === v.exp_wb_data) else begin
			$display("[FAIL] %0t ns: row %0d wb_data is %h, expected %h",
				$time, idx, wb_data, v.exp_wb_data);
			errors++;
		end
	endtask

	initial begin : watchdog
		while (cycle_limit == 0 || cycle_count < cycle_limit) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: the table did not finish within %0d cycles", cycle_limit);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		reset = 1'b1;
		rd_en = 1'b0;
		rd_addr = '0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		load_table();
		cycle_limit = 2 * table_q.size() + RESET_CYCLES + 20;

		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// outputs settle after the falling edge, sample 1 ns before the rising edge
		for (int i = 0; i < table_q.size(); i++) begin
			drive_row(table_q[i]);
			#(CLOCK_PERIOD / 2 - 1);
			check_row(i, table_q[i]);
			@(negedge clock);
		end

		$display("summary: %0d rows applied, %0d errors", table_q.size(), errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hdl
+incdir+sim
hdl/cache_pkg.sv
hdl/tag_match.sv
hdl/plru_tree.sv
hdl/cache_array.sv
hdl/victim_buffer.sv
hdl/l1_cache_top.sv
sim/cache_tb.sv

// ==== Bender.yml ====
package:
  name: l1_cache

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cache_pkg.sv
      - hdl/tag_match.sv
      - hdl/plru_tree.sv
      - hdl/cache_array.sv
      - hdl/victim_buffer.sv
      - hdl/l1_cache_top.sv
  - target: simulation
    include_dirs:
      - hdl
      - sim
    files:
      - sim/cache_tb.sv
